// ==== sim.f ====
design/rv64_decode_pkg.sv
design/rv64_func_matcher.sv
design/rv64_field_extractor.sv
design/rv64_operand_select.sv
design/rv64_instr_decoder.sv
dv/rv64_instr_decoder_asserts.sv
dv/rv64_instr_decoder_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := rv64_instr_decoder_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Checks failed

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/rv64_instr_decoder_tb.sv ====
// Table-driven testbench for the RV64IM decode stage at XLEN 64
// Each table entry is applied for one cycle and checked one cycle later

`timescale 1ns/1ps

module rv64_instr_decoder_tb;

  localparam int XLEN            = 64;
  localparam int CLK_PERIOD      = 20;
  localparam int NUM_VEC         = 34;
  localparam int WATCHDOG_CYCLES = NUM_VEC * 3 + 40;

  typedef struct packed {
    logic                      valid;
    logic [31:0]               code;
    int                        func;  // -1 when no function matches
    rv64_decode_pkg::reg_idx_t rd;
    rv64_decode_pkg::reg_idx_t rs1;
    rv64_decode_pkg::reg_idx_t rs2;
    logic [XLEN-1:0]           imm;
    logic                      jump;
  } vec_t;

  logic                      clk_i = 1'b0;
  logic                      reset_i;
  logic                      valid_i;
  logic [31:0]               code_i;
  logic [XLEN-1:0]           pc_i;
  logic                      valid_o;
  rv64_decode_pkg::decoded_t cmd_o;
  logic [XLEN-1:0]           imm_o;
  logic [XLEN-1:0]           pc_o;

  vec_t            vectors [NUM_VEC];
  logic [XLEN-1:0] pc_sent [NUM_VEC];
  logic [31:0]     seed;
  int              err_count;
  int              check_count;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  rv64_instr_decoder #(
    .XLEN(XLEN)
  ) dut (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .valid_i(valid_i),
    .code_i (code_i),
    .pc_i   (pc_i),
    .valid_o(valid_o),
    .cmd_o  (cmd_o),
    .imm_o  (imm_o),
    .pc_o   (pc_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic vec_t make_vec(input logic [31:0] code, input int func, input int rd,
                                    input int rs1, input int rs2,
                                    input logic [XLEN-1:0] imm, input int jump);
    vec_t v;
    v.valid = 1'b1;
    v.code  = code;
    v.func  = func;
    v.rd    = rd[4:0];
    v.rs1   = rs1[4:0];
    v.rs2   = rs2[4:0];
    v.imm   = imm;
    v.jump  = (jump != 0);
    return v;
  endfunction

  ////////////////////
  // Vector table
  ////////////////////

  task automatic load_vectors();
    vectors[0]  = make_vec(32'h123452B7, rv64_decode_pkg::LUI, 5, 0, 0, 64'h12345, 0);
    vectors[1]  = make_vec(32'hFFFFF097, rv64_decode_pkg::AUIPC, 1, 0, 0, 64'hFFFFF, 0);
    vectors[2]  = make_vec(32'hFF9FF0EF, rv64_decode_pkg::JAL, 1, 0, 0, -64'd8, 1);
    vectors[3]  = make_vec(32'hFFC381E7, rv64_decode_pkg::JALR, 3, 7, 0, -64'd4, 1);
    vectors[4]  = make_vec(32'hFE2088E3, rv64_decode_pkg::BEQ, 0, 1, 2, -64'd16, 1);
    vectors[5]  = make_vec(32'h00B57463, rv64_decode_pkg::BGEU, 0, 10, 11, 64'd8, 1);
    vectors[6]  = make_vec(32'hFF813303, rv64_decode_pkg::LD, 6, 2, 0, -64'd8, 0);
    vectors[7]  = make_vec(32'h0644C203, rv64_decode_pkg::LBU, 4, 9, 0, 64'd100, 0);
    vectors[8]  = make_vec(32'hFFF00093, rv64_decode_pkg::ADDI, 1, 0, 0, -64'd1, 0);
    vectors[9]  = make_vec(32'h7FF3029B, rv64_decode_pkg::ADDIW, 5, 6, 0, 64'd2047, 0);
    vectors[10] = make_vec(32'h0F04F413, rv64_decode_pkg::ANDI, 8, 9, 0, 64'hF0, 0);
    vectors[11] = make_vec(32'hFE513423, rv64_decode_pkg::SD, 0, 2, 5, -64'd24, 0);
    vectors[12] = make_vec(32'h007182A3, rv64_decode_pkg::SB, 0, 3, 7, 64'd5, 0);
    vectors[13] = make_vec(32'h03F21193, rv64_decode_pkg::SLLI, 3, 4, 0, 64'd63, 0);
    vectors[14] = make_vec(32'h4212D293, rv64_decode_pkg::SRAI, 5, 5, 0, 64'd33, 0);
    vectors[15] = make_vec(32'h41F1509B, rv64_decode_pkg::SRAIW, 1, 2, 0, 64'd31, 0);
    vectors[16] = make_vec(32'h003100B3, rv64_decode_pkg::ADD, 1, 2, 3, 64'd0, 0);
    vectors[17] = make_vec(32'h003100B3, rv64_decode_pkg::ADD, 1, 2, 3, 64'd0, 0);
    vectors[17].valid = 1'b0;  // Bubble
    vectors[18] = make_vec(32'h40C58533, rv64_decode_pkg::SUB, 10, 11, 12, 64'd0, 0);
    vectors[19] = make_vec(32'h4062D23B, rv64_decode_pkg::SRAW, 4, 5, 6, 64'd0, 0);
    vectors[20] = make_vec(32'h029403B3, rv64_decode_pkg::MUL, 7, 8, 9, 64'd0, 0);
    vectors[21] = make_vec(32'h023170B3, rv64_decode_pkg::REMU, 1, 2, 3, 64'd0, 0);
    vectors[22] = make_vec(32'h027342BB, rv64_decode_pkg::DIVW, 5, 6, 7, 64'd0, 0);
    vectors[23] = make_vec(32'h03DF7FBB, rv64_decode_pkg::REMUW, 31, 30, 29, 64'd0, 0);
    vectors[24] = make_vec(32'h0FF0000F, rv64_decode_pkg::FENCE, 0, 0, 0, 64'd255, 0);
    vectors[25] = make_vec(32'h8330000F, rv64_decode_pkg::FENCE_TSO, 0, 0, 0,
                           64'hFFFF_FFFF_FFFF_F833, 0);
    vectors[26] = make_vec(32'h0100000F, rv64_decode_pkg::PAUSE, 0, 0, 0, 64'd16, 0);
    vectors[27] = make_vec(32'h00000073, rv64_decode_pkg::ECALL, 0, 0, 0, 64'd0, 0);
    vectors[28] = make_vec(32'h00100073, rv64_decode_pkg::EBREAK, 0, 0, 0, 64'd1, 0);
    vectors[29] = make_vec(32'h30200073, rv64_decode_pkg::MRET, 0, 0, 0, 64'd0, 1);
    vectors[30] = make_vec(32'h10500073, rv64_decode_pkg::WFI, 0, 0, 0, 64'd0, 1);
    vectors[31] = make_vec(32'h00012087, -1, 0, 0, 0, 64'd0, 0);  // FLW
    vectors[32] = make_vec(32'h300110F3, -1, 0, 0, 0, 64'd0, 0);  // CSRRW
    vectors[33] = make_vec(32'h00000013, rv64_decode_pkg::ADDI, 0, 0, 0, 64'd0, 0);
  endtask

  task automatic report_mismatch(input string ctx, input string what,
                                 input logic [127:0] got, input logic [127:0] exp);
    err_count++;
    $display("MISMATCH %0t: %s %s got %0h expected %0h", $time, ctx, what, got, exp);
  endtask

  task automatic apply_vector(input int k);
    logic [31:0] pc_hi;
    seed  = lcg_next(seed);
    pc_hi = seed;
    seed  = lcg_next(seed);
    pc_sent[k] = {pc_hi, seed[31:2], 2'b00};
    valid_i = vectors[k].valid;
    code_i  = vectors[k].code;
    pc_i    = pc_sent[k];
  endtask

  task automatic check_outputs(input int k);
    vec_t                       v;
    string                      ctx;
    rv64_decode_pkg::func_vec_t one;
    rv64_decode_pkg::func_vec_t exp_func;
    rv64_decode_pkg::reg_mask_t exp_req;
    v   = vectors[k];
    ctx = $sformatf("entry %0d code %h", k, v.code);
    one = {{(rv64_decode_pkg::NUM_FUNC-1){1'b0}}, 1'b1};
    check_count++;
    if (valid_o !== v.valid) report_mismatch(ctx, "valid_o", 128'(valid_o), 128'(v.valid));
    if (v.valid) begin
      exp_func = '0;
      if (v.func >= 0) exp_func = one << v.func;
      // Loose FENCE pattern also catches these two
      if (v.func == rv64_decode_pkg::FENCE_TSO || v.func == rv64_decode_pkg::PAUSE) begin
        exp_func = exp_func | (one << rv64_decode_pkg::FENCE);
      end
      exp_req         = v.jump ? '1 : '0;
      exp_req[v.rd]   = 1'b1;
      exp_req[v.rs1]  = 1'b1;
      exp_req[v.rs2]  = 1'b1;
      if (cmd_o.func !== exp_func) report_mismatch(ctx, "func", 128'(cmd_o.func), 128'(exp_func));
      if (cmd_o.rd !== v.rd) report_mismatch(ctx, "rd", 128'(cmd_o.rd), 128'(v.rd));
      if (cmd_o.rs1 !== v.rs1) report_mismatch(ctx, "rs1", 128'(cmd_o.rs1), 128'(v.rs1));
      if (cmd_o.rs2 !== v.rs2) report_mismatch(ctx, "rs2", 128'(cmd_o.rs2), 128'(v.rs2));
      if (cmd_o.jump !== v.jump) report_mismatch(ctx, "jump", 128'(cmd_o.jump), 128'(v.jump));
      if (cmd_o.reg_req !== exp_req) begin
        report_mismatch(ctx, "reg_req", 128'(cmd_o.reg_req), 128'(exp_req));
      end
      if (imm_o !== v.imm) report_mismatch(ctx, "imm", 128'(imm_o), 128'(v.imm));
      if (pc_o !== pc_sent[k]) report_mismatch(ctx, "pc", 128'(pc_o), 128'(pc_sent[k]));
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    reset_i     = 1'b1;
    valid_i     = 1'b0;
    code_i      = '0;
    pc_i        = '0;
    err_count   = 0;
    check_count = 0;
    seed        = 32'd70454;
    load_vectors();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    check_count++;
    if (valid_o !== 1'b0 || cmd_o !== '0 || imm_o !== '0 || pc_o !== '0) begin
      report_mismatch("reset", "valid/cmd/imm/pc", 128'({valid_o, imm_o}), 128'(0));
    end
    reset_i = 1'b0;
    for (int k = 0; k <= NUM_VEC; k++) begin
      if (k > 0) check_outputs(k - 1);
      if (k < NUM_VEC) apply_vector(k);
      else valid_i = 1'b0;
      @(negedge clk_i);
    end
    $display("Decode run: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== dv/rv64_instr_decoder_asserts.sv ====
// Bound checks on the registered decode outputs
// Sampled on the rising clock; data checks hold off while reset is high

`timescale 1ns/1ps

module rv64_instr_decoder_asserts (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      valid_o,
  input rv64_decode_pkg::decoded_t cmd_o
);

  // Output register is cleared by reset
  a_idle_after_reset: assert property (
    @(posedge clk_i) reset_i |=> !valid_o
  ) else $error("valid_o high in the cycle after reset");

  // FENCE_TSO and PAUSE share their match with FENCE
  a_func_onehot: assert property (
    @(posedge clk_i) disable iff (reset_i)
      !cmd_o.func[rv64_decode_pkg::FENCE] |-> $onehot0(cmd_o.func)
  ) else $error("several function bits set without FENCE");

  a_jump_mask: assert property (
    @(posedge clk_i) disable iff (reset_i)
      cmd_o.jump |-> (&cmd_o.reg_req)
  ) else $error("jump set without a full register mask");

endmodule

bind rv64_instr_decoder rv64_instr_decoder_asserts u_asserts (
  .clk_i  (clk_i),
  .reset_i(reset_i),
  .valid_o(valid_o),
  .cmd_o  (cmd_o)
);

// ==== design/rv64_instr_decoder.sv ====
// RV64IM decode stage with one cycle of latency and no back-pressure
// A new word may enter every cycle; the consumer takes every valid_o

`timescale 1ns/1ps

module rv64_instr_decoder #(
  parameter int XLEN = rv64_decode_pkg::XLEN_DEFAULT
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      valid_i,
  input  logic [31:0]               code_i,
  input  logic [XLEN-1:0]           pc_i,
  output logic                      valid_o,
  output rv64_decode_pkg::decoded_t cmd_o,
  output logic [XLEN-1:0]           imm_o,
  output logic [XLEN-1:0]           pc_o
);

  rv64_decode_pkg::func_vec_t func;
  logic [XLEN-1:0]            imm_shamt;
  logic [XLEN-1:0]            imm_i;
  logic [XLEN-1:0]            imm_s;
  logic [XLEN-1:0]            imm_b;
  logic [XLEN-1:0]            imm_u;
  logic [XLEN-1:0]            imm_j;

  rv64_func_matcher u_matcher (
    .code_i(code_i),
    .func_o(func)
  );

  rv64_field_extractor #(
    .XLEN(XLEN)
  ) u_extractor (
    .code_i     (code_i),
    .imm_shamt_o(imm_shamt),
    .imm_i_o    (imm_i),
    .imm_s_o    (imm_s),
    .imm_b_o    (imm_b),
    .imm_u_o    (imm_u),
    .imm_j_o    (imm_j)
  );

  rv64_operand_select #(
    .XLEN(XLEN)
  ) u_select (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .valid_i    (valid_i),
    .code_i     (code_i),
    .pc_i       (pc_i),
    .func_i     (func),
    .imm_shamt_i(imm_shamt),
    .imm_i_i    (imm_i),
    .imm_s_i    (imm_s),
    .imm_b_i    (imm_b),
    .imm_u_i    (imm_u),
    .imm_j_i    (imm_j),
    .valid_o    (valid_o),
    .cmd_o      (cmd_o),
    .imm_o      (imm_o),
    .pc_o       (pc_o)
  );

endmodule

// ==== design/rv64_operand_select.sv ====
// Operand and immediate selection by function class, one register stage
// Classes are ranges of func_e, so they follow the package enum order
// Output data is captured every clock, valid_o marks the useful cycles

`timescale 1ns/1ps

module rv64_operand_select #(
  parameter int XLEN = rv64_decode_pkg::XLEN_DEFAULT
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       valid_i,
  input  rv64_decode_pkg::instr_u    code_i,
  input  logic [XLEN-1:0]            pc_i,
  input  rv64_decode_pkg::func_vec_t func_i,
  input  logic [XLEN-1:0]            imm_shamt_i,
  input  logic [XLEN-1:0]            imm_i_i,
  input  logic [XLEN-1:0]            imm_s_i,
  input  logic [XLEN-1:0]            imm_b_i,
  input  logic [XLEN-1:0]            imm_u_i,
  input  logic [XLEN-1:0]            imm_j_i,
  output logic                       valid_o,
  output rv64_decode_pkg::decoded_t  cmd_o,
  output logic [XLEN-1:0]            imm_o,
  output logic [XLEN-1:0]            pc_o
);

  function automatic rv64_decode_pkg::func_vec_t span(input int lo, input int hi);
    rv64_decode_pkg::func_vec_t v;
    v = '0;
    for (int k = lo; k <= hi; k++) begin
      v[k] = 1'b1;
    end
    return v;
  endfunction

  ////////////////////
  // Class masks
  ////////////////////

  localparam rv64_decode_pkg::func_vec_t RD_MASK =
      span(rv64_decode_pkg::LUI, rv64_decode_pkg::JALR) |
      span(rv64_decode_pkg::LB, rv64_decode_pkg::FENCE) |
      span(rv64_decode_pkg::SLLI, rv64_decode_pkg::REMUW);
  localparam rv64_decode_pkg::func_vec_t RS1_MASK =
      span(rv64_decode_pkg::JALR, rv64_decode_pkg::REMUW);
  localparam rv64_decode_pkg::func_vec_t RS2_MASK =
      span(rv64_decode_pkg::BEQ, rv64_decode_pkg::BGEU) |
      span(rv64_decode_pkg::SB, rv64_decode_pkg::SD) |
      span(rv64_decode_pkg::ADD, rv64_decode_pkg::REMUW);
  localparam rv64_decode_pkg::func_vec_t SHAMT_MASK =
      span(rv64_decode_pkg::SLLI, rv64_decode_pkg::SRAIW);
  localparam rv64_decode_pkg::func_vec_t B_MASK =
      span(rv64_decode_pkg::BEQ, rv64_decode_pkg::BGEU);
  localparam rv64_decode_pkg::func_vec_t I_MASK =
      span(rv64_decode_pkg::JALR, rv64_decode_pkg::JALR) |
      span(rv64_decode_pkg::LB, rv64_decode_pkg::FENCE) |
      span(rv64_decode_pkg::FENCE_TSO, rv64_decode_pkg::EBREAK);
  localparam rv64_decode_pkg::func_vec_t J_MASK =
      span(rv64_decode_pkg::JAL, rv64_decode_pkg::JAL);
  localparam rv64_decode_pkg::func_vec_t S_MASK =
      span(rv64_decode_pkg::SB, rv64_decode_pkg::SD);
  localparam rv64_decode_pkg::func_vec_t U_MASK =
      span(rv64_decode_pkg::LUI, rv64_decode_pkg::AUIPC);
  localparam rv64_decode_pkg::func_vec_t JUMP_MASK =
      span(rv64_decode_pkg::JAL, rv64_decode_pkg::BGEU) |
      span(rv64_decode_pkg::MRET, rv64_decode_pkg::WFI);

  typedef struct packed {
    logic rd;
    logic rs1;
    logic rs2;
  } use_t;

  typedef struct packed {
    logic shamt;
    logic b;
    logic i;
    logic j;
    logic s;
    logic u;
  } fmt_t;

  use_t                      uses;
  fmt_t                      fmt;
  rv64_decode_pkg::decoded_t cmd_d;
  logic [XLEN-1:0]           imm_d;

  always_comb begin
    uses.rd   = |(func_i & RD_MASK);
    uses.rs1  = |(func_i & RS1_MASK);
    uses.rs2  = |(func_i & RS2_MASK);
    fmt.shamt = |(func_i & SHAMT_MASK);
    fmt.b     = |(func_i & B_MASK);
    fmt.i     = |(func_i & I_MASK);
    fmt.j     = |(func_i & J_MASK);
    fmt.s     = |(func_i & S_MASK);
    fmt.u     = |(func_i & U_MASK);
  end

  always_comb begin
    cmd_d.func = func_i;
    cmd_d.rd   = uses.rd  ? code_i.r_fmt.rd  : '0;
    cmd_d.rs1  = uses.rs1 ? code_i.r_fmt.rs1 : '0;
    cmd_d.rs2  = uses.rs2 ? code_i.r_fmt.rs2 : '0;
    cmd_d.jump = |(func_i & JUMP_MASK);
    // Unused operands read as x0, so bit 0 is set for them
    cmd_d.reg_req            = {rv64_decode_pkg::NUM_REGS{cmd_d.jump}};
    cmd_d.reg_req[cmd_d.rd]  = 1'b1;
    cmd_d.reg_req[cmd_d.rs1] = 1'b1;
    cmd_d.reg_req[cmd_d.rs2] = 1'b1;
  end

  // Format priority
  always_comb begin
    if (fmt.shamt) imm_d = imm_shamt_i;
    else if (fmt.b) imm_d = imm_b_i;
    else if (fmt.i) imm_d = imm_i_i;
    else if (fmt.j) imm_d = imm_j_i;
    else if (fmt.s) imm_d = imm_s_i;
    else if (fmt.u) imm_d = imm_u_i;
    else imm_d = '0;
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
      cmd_o   <= '0;
      imm_o   <= '0;
      pc_o    <= '0;
    end else begin
      valid_o <= valid_i;
      cmd_o   <= cmd_d;
      imm_o   <= imm_d;
      pc_o    <= pc_i;
    end
  end

endmodule

// ==== design/rv64_field_extractor.sv ====
// Candidate immediates of every format, all formed in parallel
// Shift amount is 6 bits wide for any XLEN; U immediate is not shifted

`timescale 1ns/1ps

module rv64_field_extractor #(
  parameter int XLEN = rv64_decode_pkg::XLEN_DEFAULT
) (
  input  rv64_decode_pkg::instr_u code_i,
  output logic [XLEN-1:0]         imm_shamt_o,
  output logic [XLEN-1:0]         imm_i_o,
  output logic [XLEN-1:0]         imm_s_o,
  output logic [XLEN-1:0]         imm_b_o,
  output logic [XLEN-1:0]         imm_u_o,
  output logic [XLEN-1:0]         imm_j_o
);

  logic sign;

  assign sign = code_i.i_fmt.imm[11];  // Word bit 31

  // Word bits 25:20
  assign imm_shamt_o = {{(XLEN-6){1'b0}}, code_i.i_fmt.imm[5:0]};

  assign imm_i_o = {{(XLEN-12){sign}}, code_i.i_fmt.imm};

  assign imm_s_o = {{(XLEN-12){sign}}, code_i.s_fmt.imm_hi, code_i.s_fmt.imm_lo};

  // Branch offsets are halfword aligned
  assign imm_b_o = {
    {(XLEN-13){sign}},
    code_i.b_fmt.imm_12,
    code_i.b_fmt.imm_11,
    code_i.b_fmt.imm_10_5,
    code_i.b_fmt.imm_4_1,
    1'b0
  };

  assign imm_u_o = {{(XLEN-20){1'b0}}, code_i.u_fmt.imm};  // Upper bits in [19:0]

  assign imm_j_o = {
    {(XLEN-21){sign}},
    code_i.j_fmt.imm_20,
    code_i.j_fmt.imm_19_12,
    code_i.j_fmt.imm_11,
    code_i.j_fmt.imm_10_1,
    1'b0
  };

endmodule

// ==== design/rv64_func_matcher.sv ====
// Mask and match of the word against the RV64I, M and privileged maps
// FENCE matches loosely, so FENCE_TSO and PAUSE also raise the FENCE bit
// Purely combinational

`timescale 1ns/1ps

module rv64_func_matcher (
  input  rv64_decode_pkg::instr_u    code_i,
  output rv64_decode_pkg::func_vec_t func_o
);

  typedef struct packed {
    logic [31:0] mask;
    logic [31:0] match;
  } pat_t;

  function automatic pat_t pattern(input rv64_decode_pkg::func_e f);
    pat_t p;
    case (f)
      rv64_decode_pkg::LUI:       p = '{32'h0000007F, 32'h00000037};
      rv64_decode_pkg::AUIPC:     p = '{32'h0000007F, 32'h00000017};
      rv64_decode_pkg::JAL:       p = '{32'h0000007F, 32'h0000006F};
      rv64_decode_pkg::JALR:      p = '{32'h0000707F, 32'h00000067};
      rv64_decode_pkg::BEQ:       p = '{32'h0000707F, 32'h00000063};
      rv64_decode_pkg::BNE:       p = '{32'h0000707F, 32'h00001063};
      rv64_decode_pkg::BLT:       p = '{32'h0000707F, 32'h00004063};
      rv64_decode_pkg::BGE:       p = '{32'h0000707F, 32'h00005063};
      rv64_decode_pkg::BLTU:      p = '{32'h0000707F, 32'h00006063};
      rv64_decode_pkg::BGEU:      p = '{32'h0000707F, 32'h00007063};
      rv64_decode_pkg::LB:        p = '{32'h0000707F, 32'h00000003};
      rv64_decode_pkg::LH:        p = '{32'h0000707F, 32'h00001003};
      rv64_decode_pkg::LW:        p = '{32'h0000707F, 32'h00002003};
      rv64_decode_pkg::LBU:       p = '{32'h0000707F, 32'h00004003};
      rv64_decode_pkg::LHU:       p = '{32'h0000707F, 32'h00005003};
      rv64_decode_pkg::LWU:       p = '{32'h0000707F, 32'h00006003};
      rv64_decode_pkg::LD:        p = '{32'h0000707F, 32'h00003003};
      rv64_decode_pkg::ADDI:      p = '{32'h0000707F, 32'h00000013};
      rv64_decode_pkg::SLTI:      p = '{32'h0000707F, 32'h00002013};
      rv64_decode_pkg::SLTIU:     p = '{32'h0000707F, 32'h00003013};
      rv64_decode_pkg::XORI:      p = '{32'h0000707F, 32'h00004013};
      rv64_decode_pkg::ORI:       p = '{32'h0000707F, 32'h00006013};
      rv64_decode_pkg::ANDI:      p = '{32'h0000707F, 32'h00007013};
      rv64_decode_pkg::ADDIW:     p = '{32'h0000707F, 32'h0000001B};
      rv64_decode_pkg::FENCE:     p = '{32'h0000707F, 32'h0000000F};
      rv64_decode_pkg::SB:        p = '{32'h0000707F, 32'h00000023};
      rv64_decode_pkg::SH:        p = '{32'h0000707F, 32'h00001023};
      rv64_decode_pkg::SW:        p = '{32'h0000707F, 32'h00002023};
      rv64_decode_pkg::SD:        p = '{32'h0000707F, 32'h00003023};
      // 64-bit shifts leave bit 25 to the shift amount
      rv64_decode_pkg::SLLI:      p = '{32'hFC00707F, 32'h00001013};
      rv64_decode_pkg::SRLI:      p = '{32'hFC00707F, 32'h00005013};
      rv64_decode_pkg::SRAI:      p = '{32'hFC00707F, 32'h40005013};
      rv64_decode_pkg::SLLIW:     p = '{32'hFE00707F, 32'h0000101B};
      rv64_decode_pkg::SRLIW:     p = '{32'hFE00707F, 32'h0000501B};
      rv64_decode_pkg::SRAIW:     p = '{32'hFE00707F, 32'h4000501B};
      rv64_decode_pkg::ADD:       p = '{32'hFE00707F, 32'h00000033};
      rv64_decode_pkg::SUB:       p = '{32'hFE00707F, 32'h40000033};
      rv64_decode_pkg::SLL:       p = '{32'hFE00707F, 32'h00001033};
      rv64_decode_pkg::SLT:       p = '{32'hFE00707F, 32'h00002033};
      rv64_decode_pkg::SLTU:      p = '{32'hFE00707F, 32'h00003033};
      rv64_decode_pkg::XOR:       p = '{32'hFE00707F, 32'h00004033};
      rv64_decode_pkg::SRL:       p = '{32'hFE00707F, 32'h00005033};
      rv64_decode_pkg::SRA:       p = '{32'hFE00707F, 32'h40005033};
      rv64_decode_pkg::OR:        p = '{32'hFE00707F, 32'h00006033};
      rv64_decode_pkg::AND:       p = '{32'hFE00707F, 32'h00007033};
      rv64_decode_pkg::ADDW:      p = '{32'hFE00707F, 32'h0000003B};
      rv64_decode_pkg::SUBW:      p = '{32'hFE00707F, 32'h4000003B};
      rv64_decode_pkg::SLLW:      p = '{32'hFE00707F, 32'h0000103B};
      rv64_decode_pkg::SRLW:      p = '{32'hFE00707F, 32'h0000503B};
      rv64_decode_pkg::SRAW:      p = '{32'hFE00707F, 32'h4000503B};
      // M extension
      rv64_decode_pkg::MUL:       p = '{32'hFE00707F, 32'h02000033};
      rv64_decode_pkg::MULH:      p = '{32'hFE00707F, 32'h02001033};
      rv64_decode_pkg::MULHSU:    p = '{32'hFE00707F, 32'h02002033};
      rv64_decode_pkg::MULHU:     p = '{32'hFE00707F, 32'h02003033};
      rv64_decode_pkg::DIV:       p = '{32'hFE00707F, 32'h02004033};
      rv64_decode_pkg::DIVU:      p = '{32'hFE00707F, 32'h02005033};
      rv64_decode_pkg::REM:       p = '{32'hFE00707F, 32'h02006033};
      rv64_decode_pkg::REMU:      p = '{32'hFE00707F, 32'h02007033};
      rv64_decode_pkg::MULW:      p = '{32'hFE00707F, 32'h0200003B};
      rv64_decode_pkg::DIVW:      p = '{32'hFE00707F, 32'h0200403B};
      rv64_decode_pkg::DIVUW:     p = '{32'hFE00707F, 32'h0200503B};
      rv64_decode_pkg::REMW:      p = '{32'hFE00707F, 32'h0200603B};
      rv64_decode_pkg::REMUW:     p = '{32'hFE00707F, 32'h0200703B};
      // Full-word encodings
      rv64_decode_pkg::FENCE_TSO: p = '{32'hFFFFFFFF, 32'h8330000F};
      rv64_decode_pkg::PAUSE:     p = '{32'hFFFFFFFF, 32'h0100000F};
      rv64_decode_pkg::ECALL:     p = '{32'hFFFFFFFF, 32'h00000073};
      rv64_decode_pkg::EBREAK:    p = '{32'hFFFFFFFF, 32'h00100073};
      rv64_decode_pkg::MRET:      p = '{32'hFFFFFFFF, 32'h30200073};
      rv64_decode_pkg::WFI:       p = '{32'hFFFFFFFF, 32'h10500073};
      default:                    p = '{mask: '0, match: '1};  // Never matches
    endcase
    return p;
  endfunction

  ////////////////////
  // One comparator per function
  ////////////////////

  for (genvar f = 0; f < rv64_decode_pkg::NUM_FUNC; f++) begin : g_match
    localparam pat_t P = pattern(rv64_decode_pkg::func_e'(f));
    assign func_o[f] = ((code_i & P.mask) == P.match);
  end

endmodule

// ==== design/rv64_decode_pkg.sv ====
// Shared types for the RV64IM decode stage
// Function order matters: operand classes are built from contiguous ranges
// F, D, A and Zicsr words are not decoded and give an empty function vector

package rv64_decode_pkg;

  localparam int XLEN_DEFAULT = 64;

  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [NUM_REGS-1:0]  reg_mask_t;

  ////////////////////
  // Function index
  ////////////////////

  typedef enum int {
    LUI, AUIPC,                                     // U-format
    JAL,
    JALR,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,                 // B-format
    // I-format run from LB up to FENCE
    LB, LH, LW, LBU, LHU, LWU, LD,
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI, ADDIW,
    FENCE,
    SB, SH, SW, SD,                                 // S-format
    SLLI, SRLI, SRAI, SLLIW, SRLIW, SRAIW,          // Shift amount
    // R-format run from ADD up to REMUW
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    ADDW, SUBW, SLLW, SRLW, SRAW,
    MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
    MULW, DIVW, DIVUW, REMW, REMUW,
    // No register operands
    FENCE_TSO, PAUSE, ECALL, EBREAK,
    MRET, WFI
  } func_e;

  localparam int NUM_FUNC = WFI + 1;

  typedef logic [NUM_FUNC-1:0] func_vec_t;  // One-hot, indexed by func_e

  ////////////////////
  // Instruction word views
  ////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;  // imm[11:5]
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;  // imm[4:0]
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  // Decoded result without the XLEN-wide immediate and pc
  typedef struct packed {
    func_vec_t func;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    logic      jump;
    reg_mask_t reg_req;
  } decoded_t;

endpackage
